// ==== Bender.yml ====
package:
  name: brzrcpu

sources:
  # RTL in compile order
  - cpuPkg.sv
  - busArbiter.sv
  - registerFile.sv
  - aluUnit.sv
  - memoryInterface.sv
  - controlSequencer.sv
  - brzrCpu.sv
  # Testbench
  - target: simulation
    files:
      - tbClockGen.sv
      - tbMonitor.sv
      - brzrCpu_checker.sv
      - tbBrzr.sv

// ==== aluUnit.sv ====
`timescale 1ns/1ps
module aluUnit (
    input  logic                               Clock,
    input  logic                               arstN,
    input  cpuPkg::controlWordT                ctrl,
    input  logic [cpuPkg::DataWidth-1:0]       bus,
    output logic [cpuPkg::DataWidth-1:0]       zLowValue
);

    logic [cpuPkg::DataWidth-1:0] y;
    logic [cpuPkg::DataWidth-1:0] z;
    logic [cpuPkg::DataWidth-1:0] result;
    logic [4:0]                   shiftAmount;

    // Shift count is the low five bits of the bus
    assign shiftAmount = bus[4:0];
    assign zLowValue   = z;

    // Y is the left operand, the bus the right one
    always_comb begin
        case (ctrl.aluOp)
            cpuPkg::aluAdd:  result = y + bus;
            cpuPkg::aluSub:  result = y - bus;
            cpuPkg::aluAnd:  result = y & bus;
            cpuPkg::aluOr:   result = y | bus;
            cpuPkg::aluShl:  result = y << shiftAmount;
            // Logical right shift, zero fill
            cpuPkg::aluShr:  result = y >> shiftAmount;
            default:         result = bus;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            y <= '0;
        end else if (ctrl.yEnable) begin
            y <= bus;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            z <= '0;
        end else if (ctrl.zEnable) begin
            z <= result;
        end
    end

endmodule

// ==== brzrCpu.f ====
cpuPkg.sv
busArbiter.sv
registerFile.sv
aluUnit.sv
memoryInterface.sv
controlSequencer.sv
brzrCpu.sv
tbClockGen.sv
tbMonitor.sv
brzrCpu_checker.sv
tbBrzr.sv

// ==== brzrCpu.sv ====
`timescale 1ns/1ps
module brzrCpu #(
    parameter int MemWords = 512
) (
    input  logic                               Clock,
    input  logic                               arstN,
    input  logic                               loadEn,
    input  logic [$clog2(MemWords)-1:0]        loadAddr,
    input  logic [cpuPkg::DataWidth-1:0]       loadData,
    input  logic                               start,
    input  logic [cpuPkg::DataWidth-1:0]       inPort,
    output logic [cpuPkg::DataWidth-1:0]       outPort,
    output logic                               outStrobe,
    output logic                               halted
);

    localparam int AddrWidth = $clog2(MemWords);

    cpuPkg::controlWordT          ctrl;
    logic [cpuPkg::DataWidth-1:0] bus;
    logic [cpuPkg::DataWidth-1:0] ir;
    logic [cpuPkg::DataWidth-1:0] constantValue;
    logic [cpuPkg::DataWidth-1:0] pcValue;
    logic [cpuPkg::DataWidth-1:0] zLowValue;
    logic [cpuPkg::DataWidth-1:0] mdrValue;
    logic [cpuPkg::DataWidth-1:0] regValue;
    logic [AddrWidth-1:0]         pc;

    // C field sign-extended from 19 bits
    assign constantValue = {{(cpuPkg::DataWidth - 19){ir[18]}}, ir[18:0]};
    assign pcValue       = {{(cpuPkg::DataWidth - AddrWidth){1'b0}}, pc};

    // PC wraps inside memory, branch target wins over increment
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (ctrl.pcEnable) begin
            pc <= bus[AddrWidth-1:0];
        end else if (ctrl.incPc) begin
            pc <= pc + 1'b1;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ir <= '0;
        end else if (ctrl.irEnable) begin
            ir <= bus;
        end
    end

    // Strobe and value leave on the same edge
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            outPort   <= '0;
            outStrobe <= 1'b0;
        end else begin
            outStrobe <= ctrl.outEnable;
            if (ctrl.outEnable) begin
                outPort <= bus;
            end
        end
    end

    controlSequencer #(.MemWords(MemWords)) sequencer (
        .Clock(Clock), .arstN(arstN), .start(start), .instruction(ir),
        .bus(bus), .ctrl(ctrl), .halted(halted)
    );

    busArbiter arbiter (
        .busRequest(ctrl.busRequest), .pcValue(pcValue), .zLowValue(zLowValue),
        .mdrValue(mdrValue), .regValue(regValue), .constantValue(constantValue),
        .inPortValue(inPort), .bus(bus)
    );

    registerFile regs (
        .Clock(Clock), .arstN(arstN), .ctrl(ctrl), .instruction(ir),
        .bus(bus), .regValue(regValue)
    );

    aluUnit alu (
        .Clock(Clock), .arstN(arstN), .ctrl(ctrl), .bus(bus), .zLowValue(zLowValue)
    );

    memoryInterface #(.MemWords(MemWords)) memory (
        .Clock(Clock), .arstN(arstN), .ctrl(ctrl), .bus(bus), .loadEn(loadEn),
        .loadAddr(loadAddr), .loadData(loadData), .mdrValue(mdrValue)
    );

endmodule

// ==== brzrCpu_checker.sv ====
`timescale 1ns/1ps
module brzrCpuChecker (
    input  logic                         Clock,
    input  logic                         arstN,
    input  cpuPkg::busRequestT           busRequest,
    input  logic [cpuPkg::DataWidth-1:0] bus,
    input  logic [cpuPkg::DataWidth-1:0] pcValue,
    input  logic [cpuPkg::DataWidth-1:0] zLowValue,
    input  logic [cpuPkg::DataWidth-1:0] mdrValue,
    input  logic [cpuPkg::DataWidth-1:0] regValue,
    input  logic [cpuPkg::DataWidth-1:0] constantValue,
    input  logic [cpuPkg::DataWidth-1:0] inPortValue,
    input  logic                         outStrobe,
    input  logic                         halted
);

    int failCount = 0;
    logic [cpuPkg::DataWidth-1:0] grantedValue;

    // With a single request the masked OR is that driver's value
    assign grantedValue =
        ({cpuPkg::DataWidth{busRequest[cpuPkg::srcPc]}}       & pcValue)       |
        ({cpuPkg::DataWidth{busRequest[cpuPkg::srcZLow]}}     & zLowValue)     |
        ({cpuPkg::DataWidth{busRequest[cpuPkg::srcMdr]}}      & mdrValue)      |
        ({cpuPkg::DataWidth{busRequest[cpuPkg::srcReg]}}      & regValue)      |
        ({cpuPkg::DataWidth{busRequest[cpuPkg::srcConstant]}} & constantValue) |
        ({cpuPkg::DataWidth{busRequest[cpuPkg::srcInPort]}}   & inPortValue);

    busGrant: assert property (@(posedge Clock) disable iff (!arstN)
        (|busRequest) |-> ($onehot(busRequest) && bus == grantedValue))
        else begin
            $error("Bus value does not match a single requesting driver");
            failCount++;
        end

    noStrobeWhenHalted: assert property (@(posedge Clock) disable iff (!arstN)
        halted |-> !outStrobe)
        else begin
            $error("outStrobe high while halted");
            failCount++;
        end

    haltSticky: assert property (@(posedge Clock) disable iff (!arstN)
        halted |=> halted)
        else begin
            $error("halted dropped before reset");
            failCount++;
        end

endmodule

bind brzrCpu brzrCpuChecker cpuChecker (
    .Clock(Clock), .arstN(arstN), .busRequest(ctrl.busRequest), .bus(bus),
    .pcValue(pcValue), .zLowValue(zLowValue), .mdrValue(mdrValue),
    .regValue(regValue), .constantValue(constantValue), .inPortValue(inPort),
    .outStrobe(outStrobe), .halted(halted)
);

// ==== brzrStim.txt ====
// Hex words in order. Header: program length, inPort value, expected output count
// Then the program from address 0, then expected outputs as value and group tag
0000004D 12345678 0000001A
// register ops, R1 from inPort, R2 = 15
B0800000 6100000F 19890000 B9800000 21908000 B9800000 49890000 B9800000
51890000 B9800000 31890000 B9800000 29890000 B9800000 62000111 BA000000
// immediate ops, positive and negative C
61880100 B9800000 618FFFF8 B9800000 69880FF0 B9800000 698FFF00 B9800000
71883000 B9800000 7187FFFE B9800000 62000222 BA000000
// memory, st and ld around base R5 = 0x100 and base R0
62800100 08A80020 03280020 BB000000 09AFFFFC 038000FC BB800000 62000333
BA000000
// branches, R9 = taken marker, R10 = not taken marker
6480000A 6500000B
90000002 BD000000 90000001 BC800000 90800002 BD000000 90000001 BC800000
90880002 BD000000 90000001 BC800000 90080002 BD000000 90000001 BC800000
90900002 BD000000 90000001 BC800000 91900002 BD000000 90000001 BC800000
91980002 BD000000 90000001 BC800000 90980002 BD000000 90000001 BC800000
62000444 BA000000
// halt, the out after it never runs
D8000000 BA000000
// expected outputs, tag 0 inside a group, tag n closes group n
12345687 0 EDCBA997 0 00000008 0 1234567F 0 2B3C0000 0 00002468 0 00000111 1
12345778 0 12345670 0 00000670 0 12345600 0 12347678 0 FFFFFFFE 0 00000222 2
12345678 0 FFFFFFFE 0 00000333 3
0000000A 0 0000000B 0 0000000A 0 0000000B 0 0000000A 0 0000000B 0
0000000A 0 0000000B 0 00000444 4

// ==== busArbiter.sv ====
`timescale 1ns/1ps
module busArbiter (
    input  cpuPkg::busRequestT                 busRequest,
    input  logic [cpuPkg::DataWidth-1:0]       pcValue,
    input  logic [cpuPkg::DataWidth-1:0]       zLowValue,
    input  logic [cpuPkg::DataWidth-1:0]       mdrValue,
    input  logic [cpuPkg::DataWidth-1:0]       regValue,
    input  logic [cpuPkg::DataWidth-1:0]       constantValue,
    input  logic [cpuPkg::DataWidth-1:0]       inPortValue,
    output logic [cpuPkg::DataWidth-1:0]       bus
);

    // Fixed order: mdr, zLow, pc, reg, constant, inPort
    always_comb begin
        if (busRequest[cpuPkg::srcMdr]) begin
            bus = mdrValue;
        end else if (busRequest[cpuPkg::srcZLow]) begin
            bus = zLowValue;
        end else if (busRequest[cpuPkg::srcPc]) begin
            bus = pcValue;
        end else if (busRequest[cpuPkg::srcReg]) begin
            bus = regValue;
        end else if (busRequest[cpuPkg::srcConstant]) begin
            bus = constantValue;
        end else if (busRequest[cpuPkg::srcInPort]) begin
            bus = inPortValue;
        end else begin
            // Idle bus reads as zero
            bus = '0;
        end
    end

endmodule

// ==== controlSequencer.sv ====
`timescale 1ns/1ps
module controlSequencer #(
    parameter int MemWords = 512
) (
    input  logic                               Clock,
    input  logic                               arstN,
    input  logic                               start,
    input  logic [cpuPkg::DataWidth-1:0]       instruction,
    input  logic [cpuPkg::DataWidth-1:0]       bus,
    output cpuPkg::controlWordT                ctrl,
    output logic                               halted
);

    cpuPkg::opcodeT opcode;
    cpuPkg::aluOpT  opAlu;
    logic [1:0]     c2;
    logic [2:0]     step;
    logic [2:0]     lastStep;
    logic           running;
    logic           haltedReg;
    logic           conFlag;

    assign opcode = cpuPkg::opcodeT'(instruction[31:27]);
    assign c2     = instruction[20:19];

    // Halt shows up already in its own step
    assign halted = haltedReg | (running && step == 3'd3 && opcode == cpuPkg::opHalt);

    // Final step number per instruction class
    always_comb begin
        case (opcode)
            cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
            cpuPkg::opShl, cpuPkg::opShr, cpuPkg::opAddi, cpuPkg::opAndi,
            cpuPkg::opOri, cpuPkg::opBr:  lastStep = 3'd5;
            cpuPkg::opLd, cpuPkg::opSt:   lastStep = 3'd6;
            cpuPkg::opIn, cpuPkg::opOut:  lastStep = 3'd4;
            default:                      lastStep = 3'd3;
        endcase
    end

    // ALU function for register and immediate forms
    always_comb begin
        case (opcode)
            cpuPkg::opSub:                  opAlu = cpuPkg::aluSub;
            cpuPkg::opAnd, cpuPkg::opAndi:  opAlu = cpuPkg::aluAnd;
            cpuPkg::opOr, cpuPkg::opOri:    opAlu = cpuPkg::aluOr;
            cpuPkg::opShl:                  opAlu = cpuPkg::aluShl;
            cpuPkg::opShr:                  opAlu = cpuPkg::aluShr;
            default:                        opAlu = cpuPkg::aluAdd;
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            running   <= 1'b0;
            haltedReg <= 1'b0;
            step      <= '0;
        end else if (!running) begin
            // Idle until start, never again after halt
            if (start && !haltedReg) begin
                running <= 1'b1;
                step    <= '0;
            end
        end else if (step == lastStep) begin
            step <= '0;
            if (opcode == cpuPkg::opHalt) begin
                running   <= 1'b0;
                haltedReg <= 1'b1;
            end
        end else begin
            step <= step + 3'd1;
        end
    end

    // Condition flip-flop, C2 selects zero, nonzero, plus, minus
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            conFlag <= 1'b0;
        end else if (ctrl.conIn) begin
            case (c2)
                2'd0:    conFlag <= bus == '0;
                2'd1:    conFlag <= bus != '0;
                2'd2:    conFlag <= !bus[cpuPkg::DataWidth-1];
                default: conFlag <= bus[cpuPkg::DataWidth-1];
            endcase
        end
    end

    always_comb begin
        ctrl = '0;
        if (running) begin
            case (step)
                3'd0: begin
                    ctrl.busRequest[cpuPkg::srcPc] = 1'b1;
                    ctrl.marEnable = 1'b1;
                    ctrl.incPc     = 1'b1;
                end
                3'd1: begin
                    ctrl.memRead   = 1'b1;
                    ctrl.mdrEnable = 1'b1;
                    // Bus is free here, so park PC plus one in Y for branches
                    ctrl.busRequest[cpuPkg::srcPc] = 1'b1;
                    ctrl.yEnable = 1'b1;
                end
                3'd2: begin
                    ctrl.busRequest[cpuPkg::srcMdr] = 1'b1;
                    ctrl.irEnable = 1'b1;
                end
                3'd3: begin
                    case (opcode)
                        cpuPkg::opLd, cpuPkg::opSt: begin
                            // Base register, R0 gives zero
                            ctrl.busRequest[cpuPkg::srcReg] = 1'b1;
                            ctrl.grb     = 1'b1;
                            ctrl.baOut   = 1'b1;
                            ctrl.yEnable = 1'b1;
                        end
                        cpuPkg::opBr: begin
                            ctrl.busRequest[cpuPkg::srcReg] = 1'b1;
                            ctrl.gra   = 1'b1;
                            ctrl.rOut  = 1'b1;
                            ctrl.conIn = 1'b1;
                        end
                        cpuPkg::opIn: begin
                            ctrl.busRequest[cpuPkg::srcInPort] = 1'b1;
                            ctrl.zEnable = 1'b1;
                            ctrl.aluOp   = cpuPkg::aluPass;
                        end
                        cpuPkg::opOut: begin
                            ctrl.busRequest[cpuPkg::srcReg] = 1'b1;
                            ctrl.gra       = 1'b1;
                            ctrl.rOut      = 1'b1;
                            ctrl.outEnable = 1'b1;
                        end
                        cpuPkg::opHalt: ;
                        default: begin
                            // ALU and immediate forms take rb into Y
                            if (lastStep == 3'd5) begin
                                ctrl.busRequest[cpuPkg::srcReg] = 1'b1;
                                ctrl.grb     = 1'b1;
                                ctrl.rOut    = 1'b1;
                                ctrl.yEnable = 1'b1;
                            end
                        end
                    endcase
                end
                3'd4: begin
                    case (opcode)
                        cpuPkg::opAdd, cpuPkg::opSub, cpuPkg::opAnd, cpuPkg::opOr,
                        cpuPkg::opShl, cpuPkg::opShr: begin
                            ctrl.busRequest[cpuPkg::srcReg] = 1'b1;
                            ctrl.grc     = 1'b1;
                            ctrl.rOut    = 1'b1;
                            ctrl.zEnable = 1'b1;
                            ctrl.aluOp   = opAlu;
                        end
                        cpuPkg::opIn: begin
                            ctrl.busRequest[cpuPkg::srcZLow] = 1'b1;
                            ctrl.gra = 1'b1;
                            ctrl.rIn = 1'b1;
                        end
                        // out only waits here while outStrobe is high
                        cpuPkg::opOut: ;
                        default: begin
                            // Immediates, address and branch target use C
                            ctrl.busRequest[cpuPkg::srcConstant] = 1'b1;
                            ctrl.zEnable = 1'b1;
                            ctrl.aluOp   = opAlu;
                        end
                    endcase
                end
                3'd5: begin
                    ctrl.busRequest[cpuPkg::srcZLow] = 1'b1;
                    case (opcode)
                        cpuPkg::opLd: begin
                            // MAR and RAM see the address in the same cycle
                            ctrl.marEnable = 1'b1;
                            ctrl.memRead   = 1'b1;
                            ctrl.mdrEnable = 1'b1;
                        end
                        cpuPkg::opSt:  ctrl.marEnable = 1'b1;
                        cpuPkg::opBr:  ctrl.pcEnable = conFlag;
                        default: begin
                            ctrl.gra = 1'b1;
                            ctrl.rIn = 1'b1;
                        end
                    endcase
                end
                default: begin
                    if (opcode == cpuPkg::opLd) begin
                        ctrl.busRequest[cpuPkg::srcMdr] = 1'b1;
                        ctrl.gra = 1'b1;
                        ctrl.rIn = 1'b1;
                    end else begin
                        // st data passes through MDR into RAM
                        ctrl.busRequest[cpuPkg::srcReg] = 1'b1;
                        ctrl.gra       = 1'b1;
                        ctrl.rOut      = 1'b1;
                        ctrl.mdrEnable = 1'b1;
                        ctrl.memWrite  = 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

// ==== cpuPkg.sv ====
package cpuPkg;

    // Bus and register width
    localparam int DataWidth = 32;

    // Sixteen general registers
    localparam int regIndexWidth = 4;

    // One request bit per bus driver
    localparam int NumBusSources = 6;

    // Opcode sits in instruction bits 31 to 27
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opSt   = 5'd1,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opShr  = 5'd5,
        opShl  = 5'd6,
        opAnd  = 5'd9,
        opOr   = 5'd10,
        opAddi = 5'd12,
        opAndi = 5'd13,
        opOri  = 5'd14,
        // One branch opcode, C2 picks the condition
        opBr   = 5'd18,
        opIn   = 5'd22,
        opOut  = 5'd23,
        opHalt = 5'd27
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluShl,
        aluShr,
        aluPass
    } aluOpT;

    // Bus drivers, also the bit positions in busRequestT
    typedef enum logic [2:0] {
        srcPc,
        srcZLow,
        srcMdr,
        srcReg,
        srcConstant,
        srcInPort
    } busSourceT;

    typedef logic [NumBusSources-1:0] busRequestT;

    // One control word per T-step
    typedef struct packed {
        busRequestT busRequest;
        logic       marEnable;
        logic       mdrEnable;
        logic       irEnable;
        logic       yEnable;
        logic       zEnable;
        logic       pcEnable;
        logic       incPc;
        logic       memRead;
        logic       memWrite;
        logic       gra;
        logic       grb;
        logic       grc;
        logic       rIn;
        logic       rOut;
        logic       baOut;
        logic       conIn;
        logic       outEnable;
        aluOpT      aluOp;
    } controlWordT;

endpackage

// ==== memoryInterface.sv ====
`timescale 1ns/1ps
module memoryInterface #(
    parameter int MemWords = 512
) (
    input  logic                               Clock,
    input  logic                               arstN,
    input  cpuPkg::controlWordT                ctrl,
    input  logic [cpuPkg::DataWidth-1:0]       bus,
    input  logic                               loadEn,
    input  logic [$clog2(MemWords)-1:0]        loadAddr,
    input  logic [cpuPkg::DataWidth-1:0]       loadData,
    output logic [cpuPkg::DataWidth-1:0]       mdrValue
);

    localparam int AddrWidth = $clog2(MemWords);

    logic [cpuPkg::DataWidth-1:0] ram [MemWords];
    logic [AddrWidth-1:0]         mar;
    logic [AddrWidth-1:0]         memAddr;
    logic [cpuPkg::DataWidth-1:0] mdr;
    logic [cpuPkg::DataWidth-1:0] mdrIn;

    // MAR is transparent while it loads so ld saves a step
    assign memAddr = ctrl.marEnable ? bus[AddrWidth-1:0] : mar;

    // MDR takes RAM data on a read, the bus otherwise
    assign mdrIn    = ctrl.memRead ? ram[memAddr] : bus;
    assign mdrValue = mdr;

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            mar <= '0;
        end else if (ctrl.marEnable) begin
            mar <= bus[AddrWidth-1:0];
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            mdr <= '0;
        end else if (ctrl.mdrEnable) begin
            mdr <= mdrIn;
        end
    end

    // Program load has the port while the CPU sits idle
    always_ff @(posedge Clock) begin
        if (loadEn) begin
            ram[loadAddr] <= loadData;
        end else if (ctrl.memWrite) begin
            ram[memAddr] <= mdrIn;
        end
    end

endmodule

// ==== registerFile.sv ====
`timescale 1ns/1ps
module registerFile (
    input  logic                               Clock,
    input  logic                               arstN,
    input  cpuPkg::controlWordT                ctrl,
    input  logic [cpuPkg::DataWidth-1:0]       instruction,
    input  logic [cpuPkg::DataWidth-1:0]       bus,
    output logic [cpuPkg::DataWidth-1:0]       regValue
);

    logic [cpuPkg::DataWidth-1:0]     regs [2**cpuPkg::regIndexWidth];
    logic [cpuPkg::regIndexWidth-1:0] ra;
    logic [cpuPkg::regIndexWidth-1:0] rb;
    logic [cpuPkg::regIndexWidth-1:0] rc;
    logic [cpuPkg::regIndexWidth-1:0] index;

    // Register fields of the IR
    assign ra = instruction[26:23];
    assign rb = instruction[22:19];
    assign rc = instruction[18:15];

    // Gra wins over Grb, Grb over Grc
    always_comb begin
        if (ctrl.gra) begin
            index = ra;
        end else if (ctrl.grb) begin
            index = rb;
        end else if (ctrl.grc) begin
            index = rc;
        end else begin
            index = '0;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**cpuPkg::regIndexWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rIn) begin
            regs[index] <= bus;
        end
    end

    always_comb begin
        if (ctrl.baOut && index == '0) begin
            // R0 as a base is zero
            regValue = '0;
        end else if (ctrl.rOut || ctrl.baOut) begin
            regValue = regs[index];
        end else begin
            regValue = '0;
        end
    end

endmodule

// ==== tbBrzr.sv ====
`timescale 1ns/1ps
module tbBrzr;

    localparam int MemWords     = 512;
    localparam int AddrWidth    = $clog2(MemWords);
    localparam int MaxExpected  = 64;
    localparam int StimWords    = 256;
    localparam int LongestInstr = 7;
    localparam int QuietCycles  = 20;

    logic                         Clock;
    logic                         arstN;
    logic                         loadEn;
    logic [AddrWidth-1:0]         loadAddr;
    logic [31:0]                  loadData;
    logic                         start;
    logic [31:0]                  inPort;
    logic [31:0]                  outPort;
    logic                         outStrobe;
    logic                         halted;
    logic [31:0]                  stim [StimWords];
    logic [MaxExpected-1:0][31:0] expValues;
    logic [MaxExpected-1:0][2:0]  expGroups;
    int                           expCount;
    int                           programLength;
    int                           timeoutLimit = 0;
    int                           cycleCount = 0;
    int                           errorCount;
    int                           checkCount;
    int                           seed = 53986;

    tbClockGen #(.PeriodNs(20), .ResetCycles(2)) clockGen (.Clock(Clock), .arstN(arstN));

    brzrCpu #(.MemWords(MemWords)) uut (
        .Clock(Clock), .arstN(arstN), .loadEn(loadEn), .loadAddr(loadAddr),
        .loadData(loadData), .start(start), .inPort(inPort), .outPort(outPort),
        .outStrobe(outStrobe), .halted(halted)
    );

    tbMonitor #(.MaxExpected(MaxExpected)) monitor (
        .Clock(Clock), .arstN(arstN), .outPort(outPort), .outStrobe(outStrobe),
        .halted(halted), .expValues(expValues), .expGroups(expGroups),
        .expCount(expCount), .errorCount(errorCount), .checkCount(checkCount)
    );

    // Run limit scales with program length and the slowest instruction
    always @(posedge Clock) begin
        cycleCount++;
        if (timeoutLimit > 0 && cycleCount >= timeoutLimit) begin
            $display("Timeout after %0d cycles, the program did not finish", cycleCount);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        loadEn    = 1'b0;
        loadAddr  = '0;
        loadData  = '0;
        start     = 1'b0;
        // Filler until the program's input value is applied
        inPort    = $random(seed);
        expValues = '0;
        expGroups = '0;
        $readmemh("brzrStim.txt", stim);
        programLength = stim[0];
        expCount      = stim[2];
        if ($isunknown(stim[0]) || $isunknown(stim[2]) || programLength > MemWords ||
            expCount > MaxExpected || 3 + programLength + 2 * expCount > StimWords) begin
            $display("Stimulus file is missing or its header is out of range");
            $display("*** FAILED ***");
            $finish;
        end
        // Expected list follows the program as value and group pairs
        for (int i = 0; i < expCount; i++) begin
            expValues[i] = stim[3 + programLength + 2 * i];
            expGroups[i] = stim[4 + programLength + 2 * i][2:0];
        end
        timeoutLimit = 10 * programLength * LongestInstr;

        wait (arstN === 1'b1);
        @(negedge Clock);
        for (int i = 0; i < programLength; i++) begin
            loadEn   = 1'b1;
            loadAddr = i[AddrWidth-1:0];
            loadData = stim[3 + i];
            @(negedge Clock);
        end
        loadEn = 1'b0;
        inPort = stim[1];

        start = 1'b1;
        @(negedge Clock);
        start = 1'b0;
        while (halted !== 1'b1) @(negedge Clock);

        // A halted CPU stays quiet and ignores a second start
        repeat (QuietCycles) @(negedge Clock);
        start = 1'b1;
        @(negedge Clock);
        start = 1'b0;
        repeat (QuietCycles) @(negedge Clock);

        monitor.checkEnd();
        if (errorCount == 0 && uut.cpuChecker.failCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tbClockGen.sv ====
`timescale 1ns/1ps
module tbClockGen #(
    parameter int PeriodNs    = 20,
    parameter int ResetCycles = 2
) (
    output logic Clock,
    output logic arstN
);

    initial begin
        Clock = 1'b0;
        forever #(PeriodNs / 2) Clock = ~Clock;
    end

    // Reset held low for a few rising edges, released between edges
    initial begin
        arstN = 1'b0;
        repeat (ResetCycles) @(posedge Clock);
        @(negedge Clock);
        arstN = 1'b1;
    end

endmodule

// ==== tbMonitor.sv ====
`timescale 1ns/1ps
module tbMonitor #(
    parameter int MaxExpected = 64
) (
    input  logic                         Clock,
    input  logic                         arstN,
    input  logic [31:0]                  outPort,
    input  logic                         outStrobe,
    input  logic                         halted,
    input  logic [MaxExpected-1:0][31:0] expValues,
    input  logic [MaxExpected-1:0][2:0]  expGroups,
    input  int                           expCount,
    output int                           errorCount,
    output int                           checkCount
);

    int strobeCount;
    int groupErrors;

    function automatic string groupName(input int group);
        case (group)
            1:       return "register ops";
            2:       return "immediate ops";
            3:       return "memory";
            4:       return "branches";
            5:       return "halt";
            default: return "unknown group";
        endcase
    endfunction

    // One line per finished group
    task automatic reportGroup(input int group);
        if (groupErrors == 0) begin
            $display("Group %0d %s: ok", group, groupName(group));
        end else begin
            $display("Group %0d %s: %0d error(s)", group, groupName(group), groupErrors);
        end
        groupErrors = 0;
    endtask

    task automatic noteError();
        errorCount++;
        groupErrors++;
    endtask

    initial begin
        errorCount  = 0;
        checkCount  = 0;
        strobeCount = 0;
        groupErrors = 0;
    end

    // Registered outputs are settled by the falling edge
    always @(negedge Clock) begin
        if (arstN && outStrobe) begin
            checkCount++;
            if (halted) begin
                $display("outStrobe fired after the CPU halted");
                noteError();
            end else if (strobeCount >= expCount) begin
                $display("Extra outStrobe beyond the %0d expected outputs", expCount);
                noteError();
            end else begin
                if (outPort !== expValues[strobeCount]) begin
                    $display("Fail outPort expected %h got %h",
                             expValues[strobeCount], outPort);
                    noteError();
                end
                // A nonzero tag marks the last output of a group
                if (expGroups[strobeCount] != 0) begin
                    reportGroup(expGroups[strobeCount]);
                end
            end
            strobeCount++;
        end
    end

    // Halt state and output count once the run is over
    task automatic checkEnd();
        checkCount += 2;
        if (halted !== 1'b1) begin
            $display("CPU is not halted at the end of the run");
            noteError();
        end
        if (strobeCount != expCount) begin
            $display("Output count is %0d, expected %0d", strobeCount, expCount);
            noteError();
        end
        reportGroup(5);
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    endtask

endmodule
